// ==== Makefile ====
SIM     = verilator
FLAGS   = --binary --timing
TOP     = sie_tb
FILELIST = all.f
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
hw/sie_pkg.sv
hw/sie_regs.sv
hw/sie_tx.sv
hw/sie_rx.sv
hw/sie_top.sv
verif/sie_tb.sv

// ==== hw/sie_pkg.sv ====
`default_nettype none

package sie_pkg;

	// Register map of the processor bus
	localparam logic [5:0] REG_LINE_STATE = 6'h00;
	localparam logic [5:0] REG_DISCON     = 6'h01;
	localparam logic [5:0] REG_TX_DATA    = 6'h02; // Write only
	localparam logic [5:0] REG_TX_CREDITS = 6'h03;
	localparam logic [5:0] REG_RX_DATA    = 6'h05;
	localparam logic [5:0] REG_RX_STATUS  = 6'h06; // Bit 0 pending, bit 1 active, bit 2 error
	localparam logic [5:0] REG_GEN_RESET  = 6'h07;

	// Bit timing on a 48 MHz clock for the 12 Mb/s full-speed line
	localparam int CLKS_PER_BIT = 4;

	localparam int TX_DEPTH = 2;    // Transmit buffer entries and initial credits
	localparam int STUFF_LIMIT = 6; // Ones allowed before a zero is stuffed
	localparam int DISCON_BITS = 16;

	// Line state is {D-, D+}
	localparam logic [1:0] LS_SE0 = 2'b00;
	localparam logic [1:0] LS_J   = 2'b01;
	localparam logic [1:0] LS_K   = 2'b10;

	localparam logic [7:0] SYNC_BYTE = 8'h80; // KJKJKJKK on the line, LSB first

endpackage

`default_nettype wire

// ==== hw/sie_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module sie_regs (
	input logic usb_clk,
	input logic usb_rst,

	input logic io_re,
	input logic io_we,
	input logic [5:0] io_a,
	input logic [7:0] io_di,
	output logic [7:0] io_do,

	output logic tx_push,
	output logic [7:0] tx_byte,
	input logic tx_credit,
	output logic gen_reset,

	input logic rx_valid,
	input logic [7:0] rx_byte,
	input logic rx_active,
	input logic rx_error,
	input logic [1:0] line_state,
	input logic discon
);

	import sie_pkg::*;

	localparam int CW = $clog2(TX_DEPTH + 1);

	logic [CW-1:0] credits;
	logic [7:0] rx_data;
	logic rx_pending;

	// A write only reaches the transmitter when a buffer slot is known to be free
	assign tx_push = io_we && (io_a == REG_TX_DATA) && (credits != '0);
	assign tx_byte = io_di;

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			credits <= CW'(TX_DEPTH);
		end else if (tx_push && !tx_credit) begin
			credits <= credits - CW'(1);
		end else if (tx_credit && !tx_push) begin
			credits <= credits + CW'(1); // Slot freed as the shifter took a byte
		end
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			gen_reset <= 1'b0;
		end else if (io_we && (io_a == REG_GEN_RESET)) begin
			gen_reset <= io_di[0];
		end
	end

	// With no back-pressure a new byte simply replaces an unread one
	always_ff @(posedge usb_clk) begin
		if (rx_valid) begin
			rx_data <= rx_byte;
		end
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			rx_pending <= 1'b0;
		end else if (rx_valid) begin
			rx_pending <= 1'b1;
		end else if (io_re && (io_a == REG_RX_DATA)) begin
			rx_pending <= 1'b0; // Reading the data acknowledges it
		end
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			io_do <= 8'd0;
		end else begin
			case (io_a)
				REG_LINE_STATE: io_do <= {6'd0, line_state};
				REG_DISCON: io_do <= {7'd0, discon};
				REG_TX_CREDITS: io_do <= 8'(credits);
				REG_RX_DATA: io_do <= rx_data;
				REG_RX_STATUS: io_do <= {5'd0, rx_error, rx_active, rx_pending};
				REG_GEN_RESET: io_do <= {7'd0, gen_reset};
				default: io_do <= 8'd0; // Unmapped addresses read as zero
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/sie_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module sie_rx (
	input logic usb_clk,
	input logic usb_rst,

	input logic dp_in,
	input logic dm_in,

	output logic rx_valid,
	output logic [7:0] rx_byte,
	output logic rx_active,
	output logic rx_error,
	output logic [1:0] line_state,
	output logic discon
);

	import sie_pkg::*;

	localparam int PHW = $clog2(CLKS_PER_BIT);
	localparam int DW = $clog2(DISCON_BITS * CLKS_PER_BIT + 1);
	localparam logic [1:0] R_HUNT = 2'd0;
	localparam logic [1:0] R_DATA = 2'd1;
	localparam logic [1:0] R_EOP  = 2'd2;

	logic [1:0] ls_meta;
	logic [1:0] ls;
	logic [1:0] ls_prev;
	logic [PHW-1:0] phase;
	logic [DW-1:0] se0_cnt;
	logic [1:0] state;
	logic [7:0] hunt_sh;
	logic [7:0] data_sh;
	logic [2:0] bit_idx;
	logic [2:0] ones;
	logic prev_k;
	logic sample;
	logic line_se0;
	logic line_k;
	logic nrzi_bit;
	logic stuff;
	logic take;

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			ls_meta <= LS_J;
			ls <= LS_J;
			ls_prev <= LS_J;
		end else begin
			ls_meta <= {dm_in, dp_in}; // Two-stage synchronizer
			ls <= ls_meta;
			ls_prev <= ls;
		end
	end

	assign line_state = ls;
	assign line_se0 = (ls == LS_SE0);
	assign line_k = (ls == LS_K);
	assign nrzi_bit = (line_k == prev_k); // No transition decodes as a one
	assign stuff = (ones == 3'(STUFF_LIMIT));
	assign sample = (phase == PHW'(CLKS_PER_BIT / 2 - 1)); // Middle of the bit time
	assign take = sample && (state == R_DATA) && !line_se0 && !(stuff && !nrzi_bit);

	// Every line transition realigns the bit clock
	always_ff @(posedge usb_clk) begin
		if (usb_rst || (ls != ls_prev)) begin
			phase <= '0;
		end else if (phase == PHW'(CLKS_PER_BIT - 1)) begin
			phase <= '0;
		end else begin
			phase <= phase + PHW'(1);
		end
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			se0_cnt <= '0;
			discon <= 1'b0;
		end else if (line_se0) begin
			if (se0_cnt == DW'(DISCON_BITS * CLKS_PER_BIT)) discon <= 1'b1;
			else se0_cnt <= se0_cnt + DW'(1);
		end else begin
			se0_cnt <= '0;
			if (ls == LS_J) discon <= 1'b0;
		end
	end

	always_ff @(posedge usb_clk) begin
		if (take) begin
			data_sh <= {nrzi_bit, data_sh[7:1]};
			if (bit_idx == 3'd7) rx_byte <= {nrzi_bit, data_sh[7:1]};
		end
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			state <= R_HUNT;
			hunt_sh <= 8'hFF;
			bit_idx <= 3'd0;
			ones <= 3'd0;
			prev_k <= 1'b0;
			rx_valid <= 1'b0;
			rx_active <= 1'b0;
			rx_error <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (sample) begin
				prev_k <= line_k; // SE0 leaves the decoder expecting J
				case (state)
					R_HUNT: begin
						hunt_sh <= line_se0 ? 8'hFF : {nrzi_bit, hunt_sh[7:1]};
						if (!line_se0 && ({nrzi_bit, hunt_sh[7:1]} == SYNC_BYTE)) begin
							state <= R_DATA;
							rx_active <= 1'b1;
							rx_error <= 1'b0;
							bit_idx <= 3'd0;
							ones <= 3'd1; // Last SYNC bit counts toward stuffing
						end
					end
					R_DATA: begin
						if (line_se0) begin
							state <= R_EOP;
							if (bit_idx != 3'd0) rx_error <= 1'b1;
						end else if (stuff && !nrzi_bit) begin
							ones <= 3'd0; // Stuffed zero is dropped
						end else begin
							if (stuff) rx_error <= 1'b1; // Seventh one in a row
							if (!nrzi_bit) ones <= 3'd0;
							else if (!stuff) ones <= ones + 3'd1;
							bit_idx <= bit_idx + 3'd1;
							if (bit_idx == 3'd7) rx_valid <= 1'b1;
						end
					end
					R_EOP: begin
						if (!line_se0) begin
							state <= R_HUNT;
							rx_active <= 1'b0;
							hunt_sh <= 8'hFF;
						end
					end
					default: state <= R_HUNT;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/sie_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module sie_top (
	input logic usb_clk,
	input logic usb_rst,

	input logic io_re,
	input logic io_we,
	input logic [5:0] io_a,
	input logic [7:0] io_di,
	output logic [7:0] io_do,

	output logic dp_out,
	output logic dm_out,
	output logic line_oe,
	input logic dp_in,
	input logic dm_in
);

	logic tx_push;
	logic [7:0] tx_byte;
	logic tx_credit;
	logic gen_reset;
	logic rx_valid;
	logic [7:0] rx_byte;
	logic rx_active;
	logic rx_error;
	logic [1:0] line_state;
	logic discon;

	sie_regs regs (
		.usb_clk(usb_clk),
		.usb_rst(usb_rst),
		.io_re(io_re),
		.io_we(io_we),
		.io_a(io_a),
		.io_di(io_di),
		.io_do(io_do),
		.tx_push(tx_push),
		.tx_byte(tx_byte),
		.tx_credit(tx_credit),
		.gen_reset(gen_reset),
		.rx_valid(rx_valid),
		.rx_byte(rx_byte),
		.rx_active(rx_active),
		.rx_error(rx_error),
		.line_state(line_state),
		.discon(discon)
	);

	sie_tx tx (
		.usb_clk(usb_clk),
		.usb_rst(usb_rst),
		.tx_push(tx_push),
		.tx_byte(tx_byte),
		.tx_credit(tx_credit),
		.gen_reset(gen_reset),
		.dp_out(dp_out),
		.dm_out(dm_out),
		.line_oe(line_oe)
	);

	sie_rx rx (
		.usb_clk(usb_clk),
		.usb_rst(usb_rst),
		.dp_in(dp_in),
		.dm_in(dm_in),
		.rx_valid(rx_valid),
		.rx_byte(rx_byte),
		.rx_active(rx_active),
		.rx_error(rx_error),
		.line_state(line_state),
		.discon(discon)
	);

endmodule

`default_nettype wire

// ==== hw/sie_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module sie_tx (
	input logic usb_clk,
	input logic usb_rst,

	input logic tx_push,
	input logic [7:0] tx_byte,
	output logic tx_credit,
	input logic gen_reset,

	output logic dp_out,
	output logic dm_out,
	output logic line_oe
);

	import sie_pkg::*;

	localparam int PW = (TX_DEPTH > 1) ? $clog2(TX_DEPTH) : 1;
	localparam int CW = $clog2(TX_DEPTH + 1);
	localparam int TW = $clog2(CLKS_PER_BIT);
	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_SYNC = 2'd1;
	localparam logic [1:0] S_DATA = 2'd2;
	localparam logic [1:0] S_EOP  = 2'd3;

	logic [7:0] fifo_mem [TX_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] fill;
	logic [TW-1:0] clk_cnt;
	logic [1:0] state;
	logic [7:0] shreg;
	logic [2:0] bit_idx;
	logic [2:0] ones;
	logic [1:0] eop_cnt;
	logic lvl; // 1 drives J, 0 drives K
	logic se0;
	logic oe;
	logic tick;
	logic stuff;
	logic pop;

	function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
		return (p == PW'(TX_DEPTH - 1)) ? '0 : p + PW'(1);
	endfunction

	assign tick = (clk_cnt == TW'(CLKS_PER_BIT - 1));
	assign stuff = (ones == 3'(STUFF_LIMIT)); // Next bit time carries a stuffed zero
	assign pop = tick && ((state == S_SYNC) || (state == S_DATA)) && !stuff &&
		(bit_idx == 3'd7) && (fill != '0);
	assign tx_credit = pop;

	always_ff @(posedge usb_clk) begin
		if (usb_rst || tick) begin
			clk_cnt <= '0;
		end else begin
			clk_cnt <= clk_cnt + TW'(1);
		end
	end

	always_ff @(posedge usb_clk) begin
		if (tx_push) begin
			fifo_mem[wr_ptr] <= tx_byte;
		end
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			if (tx_push) wr_ptr <= ptr_next(wr_ptr);
			if (pop) rd_ptr <= ptr_next(rd_ptr);
			if (tx_push && !pop) fill <= fill + CW'(1);
			else if (pop && !tx_push) fill <= fill - CW'(1);
		end
	end

	always_ff @(posedge usb_clk) begin
		if (tick && (state == S_IDLE)) begin
			shreg <= SYNC_BYTE;
		end else if (pop) begin
			shreg <= fifo_mem[rd_ptr];
		end else if (tick && (state != S_EOP) && !stuff) begin
			shreg <= shreg >> 1;
		end
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			state <= S_IDLE;
			bit_idx <= 3'd0;
			ones <= 3'd0;
			eop_cnt <= 2'd0;
			lvl <= 1'b1;
			se0 <= 1'b0;
			oe <= 1'b0;
		end else if (tick) begin
			case (state)
				S_IDLE: begin
					if ((fill != '0) && !gen_reset) begin
						state <= S_SYNC; // One driven J precedes the SYNC
						oe <= 1'b1;
						bit_idx <= 3'd0;
						ones <= 3'd0;
					end
				end
				S_SYNC, S_DATA: begin
					if (stuff) begin
						lvl <= !lvl;
						ones <= 3'd0;
					end else begin
						if (shreg[0]) begin
							ones <= ones + 3'd1;
						end else begin
							lvl <= !lvl; // NRZI sends a zero as a transition
							ones <= 3'd0;
						end
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							if (fill != '0) begin
								state <= S_DATA;
							end else begin
								state <= S_EOP;
								eop_cnt <= 2'd0;
							end
						end
					end
				end
				S_EOP: begin
					if (stuff) begin
						lvl <= !lvl; // Trailing stuffed zero goes out before SE0
						ones <= 3'd0;
					end else begin
						eop_cnt <= eop_cnt + 2'd1;
						case (eop_cnt)
							2'd0: se0 <= 1'b1;
							2'd2: begin
								se0 <= 1'b0;
								lvl <= 1'b1;
							end
							2'd3: begin
								oe <= 1'b0;
								state <= S_IDLE;
							end
							default: ;
						endcase
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// A forced bus reset overrides whatever the FSM is driving
	assign line_oe = oe || gen_reset;
	assign dp_out = lvl && !se0 && !gen_reset;
	assign dm_out = !lvl && !se0 && !gen_reset;

endmodule

`default_nettype wire

// ==== verif/sie_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module sie_tb;

	import sie_pkg::*;

	localparam logic [31:0] LFSR_SEED = 32'h11e6_d354;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003; // Taps 32, 22, 2 and 1
	localparam int LOOP_PACKETS = 20;
	localparam int STUFF_PACKETS = 3;
	localparam int MAX_BYTES = 8;
	localparam int ALL_PACKETS = LOOP_PACKETS + STUFF_PACKETS + 3;
	// Each packet gets room for SYNC and EOP on top of its data bytes
	localparam int TIMEOUT_CYCLES = ALL_PACKETS * (MAX_BYTES + 2) * 10 * CLKS_PER_BIT + 3000;

	logic usb_clk;
	logic usb_rst;
	logic io_re;
	logic io_we;
	logic [5:0] io_a;
	logic [7:0] io_di;
	logic [7:0] io_do;
	logic dp_out;
	logic dm_out;
	logic line_oe;
	logic dp_in;
	logic dm_in;

	logic [1:0] drv_ls; // Level the cable carries while the DUT is not driving
	logic [31:0] lfsr;
	logic [7:0] tx_queue[$];
	logic [7:0] expected[$];
	logic err_seen;
	logic watch;
	logic [1:0] last_level;
	int run_len;
	int max_run;
	int pass_count;
	int fail_count;
	int fails_at_start;
	int cycle_count;
	string current_test;

	sie_top uut (
		.usb_clk(usb_clk),
		.usb_rst(usb_rst),
		.io_re(io_re),
		.io_we(io_we),
		.io_a(io_a),
		.io_di(io_di),
		.io_do(io_do),
		.dp_out(dp_out),
		.dm_out(dm_out),
		.line_oe(line_oe),
		.dp_in(dp_in),
		.dm_in(dm_in)
	);

	assign dp_in = line_oe ? dp_out : drv_ls[0];
	assign dm_in = line_oe ? dm_out : drv_ls[1];

	initial begin
		usb_clk = 1'b0;
		forever #5 usb_clk = ~usb_clk;
	end

	// Longest time in clocks that the driven line holds one level
	always @(negedge usb_clk) begin
		if (!watch) max_run <= 0;
		else if (run_len > max_run) max_run <= run_len;
		if (!line_oe) run_len <= 0;
		else if (({dm_out, dp_out} == last_level) && (run_len != 0)) run_len <= run_len + 1;
		else run_len <= 1;
		last_level <= {dm_out, dp_out};
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge usb_clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	task automatic take_random(input int nbits, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = lfsr_step(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("Mismatch in %s, %s: expected 0x%0h, actual 0x%0h",
				current_test, what, exp, act);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic start_test(input string name);
		current_test = name;
		fails_at_start = fail_count;
	endtask

	task automatic report_test;
		$display("Test %s: %s", current_test, (fail_count == fails_at_start) ? "passed" : "failed");
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge usb_clk);
			#1;
		end
	endtask

	task automatic write_reg(input logic [5:0] addr, input logic [7:0] data);
		io_we = 1'b1;
		io_a = addr;
		io_di = data;
		@(posedge usb_clk);
		#1;
		io_we = 1'b0;
	endtask

	task automatic read_reg(input logic [5:0] addr, output logic [7:0] data);
		io_re = 1'b1;
		io_a = addr;
		@(posedge usb_clk);
		#1;
		io_re = 1'b0;
		data = io_do; // Registered read data from the edge just passed
	endtask

	task automatic poll_receiver(output logic [7:0] status);
		logic [7:0] data;
		logic [7:0] want;
		read_reg(REG_RX_STATUS, status);
		if (status[2]) err_seen = 1'b1;
		if (status[0]) begin
			read_reg(REG_RX_DATA, data);
			if (expected.size() == 0) begin
				$display("Error in %s: byte 0x%02h received that was never sent", current_test,
					data);
				fail_count++;
			end else begin
				want = expected.pop_front();
				check_value("received byte", 32'(want), 32'(data));
			end
		end
	endtask

	// Wait until every sent byte is back and both line and receiver are idle
	task automatic drain_packet;
		logic [7:0] status;
		poll_receiver(status);
		while ((expected.size() != 0) || line_oe || status[1]) begin
			poll_receiver(status);
		end
	endtask

	task automatic send_packet;
		logic [7:0] status;
		logic [7:0] credits;
		int idx;
		idx = 0;
		while (idx < tx_queue.size()) begin
			poll_receiver(status);
			read_reg(REG_TX_CREDITS, credits);
			if (credits != 8'd0) begin
				write_reg(REG_TX_DATA, tx_queue[idx]);
				expected.push_back(tx_queue[idx]);
				idx++;
			end
		end
		drain_packet();
		read_reg(REG_TX_CREDITS, credits);
		check_value("credits after packet", TX_DEPTH, 32'(credits));
	endtask

	task automatic drive_line(input logic [1:0] level, input int bits);
		drv_ls = level;
		idle_cycles(bits * CLKS_PER_BIT);
	endtask

	task automatic send_nrzi_bit(input logic value);
		if (!value) drv_ls = (drv_ls == LS_J) ? LS_K : LS_J; // A zero is a transition
		idle_cycles(CLKS_PER_BIT);
	endtask

	initial begin
		logic [31:0] r;
		logic [7:0] rd;
		int len;
		int model_credits;
		usb_rst = 1'b1;
		io_re = 1'b0;
		io_we = 1'b0;
		io_a = REG_LINE_STATE;
		io_di = 8'd0;
		drv_ls = LS_J;
		watch = 1'b0;
		err_seen = 1'b0;
		lfsr = LFSR_SEED;
		pass_count = 0;
		fail_count = 0;
		repeat (8) @(posedge usb_clk);
		#1;
		usb_rst = 1'b0;

		start_test("reset_state");
		read_reg(REG_TX_CREDITS, rd);
		check_value("credits", TX_DEPTH, 32'(rd));
		read_reg(REG_RX_STATUS, rd);
		check_value("rx status", 32'h0, 32'(rd));
		check_value("line_oe", 32'h0, 32'(line_oe));
		read_reg(REG_LINE_STATE, rd);
		check_value("line state", 32'(LS_J), 32'(rd));
		report_test();

		start_test("loopback");
		err_seen = 1'b0;
		for (int p = 0; p < LOOP_PACKETS; p++) begin
			tx_queue.delete();
			take_random(3, r);
			len = int'(r[2:0]) + 1;
			for (int b = 0; b < len; b++) begin
				take_random(8, r);
				tx_queue.push_back(r[7:0]);
			end
			send_packet();
		end
		check_value("rx error seen", 32'h0, 32'(err_seen));
		report_test();

		start_test("credits");
		model_credits = TX_DEPTH;
		for (int b = 0; b < 3; b++) begin
			take_random(8, r);
			write_reg(REG_TX_DATA, r[7:0]);
			if (model_credits > 0) begin
				expected.push_back(r[7:0]); // A write without credit is dropped
				model_credits--;
			end
		end
		read_reg(REG_TX_CREDITS, rd);
		check_value("credits after writes", 32'(model_credits), 32'(rd));
		drain_packet();
		read_reg(REG_TX_CREDITS, rd);
		check_value("credits after packet", TX_DEPTH, 32'(rd));
		read_reg(REG_RX_STATUS, rd);
		check_value("pending after packet", 32'h0, 32'(rd[0]));
		report_test();

		start_test("bit_stuffing");
		err_seen = 1'b0;
		watch = 1'b1;
		for (int p = 0; p < STUFF_PACKETS; p++) begin
			tx_queue.delete();
			for (int b = 0; b < p + 2; b++) tx_queue.push_back(8'hFF);
			send_packet();
		end
		// All ones hit the stuffing limit and the longest run is exactly one bit over it
		check_value("longest level run", (STUFF_LIMIT + 1) * CLKS_PER_BIT, max_run);
		watch = 1'b0;
		check_value("rx error seen", 32'h0, 32'(err_seen));
		report_test();

		start_test("rx_error");
		drive_line(LS_J, 4);
		for (int i = 0; i < 8; i++) send_nrzi_bit(SYNC_BYTE[i]);
		repeat (STUFF_LIMIT + 1) send_nrzi_bit(1'b1);
		drive_line(LS_SE0, 2);
		drive_line(LS_J, 3);
		read_reg(REG_RX_STATUS, rd);
		check_value("status after bad packet", 32'h4, 32'(rd)); // Error set, idle, nothing pending
		tx_queue.delete();
		take_random(8, r);
		tx_queue.push_back(r[7:0]);
		send_packet();
		read_reg(REG_RX_STATUS, rd);
		check_value("error after clean packet", 32'h0, 32'(rd[2]));
		report_test();

		start_test("reset_discon");
		write_reg(REG_GEN_RESET, 8'd1);
		check_value("line_oe in bus reset", 32'h1, 32'(line_oe));
		check_value("driven level", 32'(LS_SE0), 32'({dm_out, dp_out}));
		idle_cycles(3);
		read_reg(REG_LINE_STATE, rd);
		check_value("line state", 32'(LS_SE0), 32'(rd));
		write_reg(REG_GEN_RESET, 8'd0);
		drive_line(LS_J, 1);
		drive_line(LS_SE0, DISCON_BITS + 1);
		idle_cycles(4);
		read_reg(REG_DISCON, rd);
		check_value("discon after SE0", 32'h1, 32'(rd));
		drive_line(LS_J, 1);
		idle_cycles(2);
		read_reg(REG_DISCON, rd);
		check_value("discon after J", 32'h0, 32'(rd));
		report_test();

		$display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
